/* common/opx_macros.svh */
// Width, depth and credit constants for the operand execute pipeline
// Data path, register index and tag widths
// Input queue depth and output credit budget

`ifndef OPX_MACROS_SVH
`define OPX_MACROS_SVH

////////////////////////////////////////
// Data path
////////////////////////////////////////

// Operand and result width
`define OPX_DATA_W 32
// Register index width, sixteen registers
`define OPX_REG_AW 4
// Sequence tag carried with every instruction
`define OPX_TAG_W 8

////////////////////////////////////////
// Flow control
////////////////////////////////////////

// Queue entries, equal to the sender's initial credits
`define OPX_IN_DEPTH 4
// Results the receiver can take before returning credit
`define OPX_OUT_CREDITS 4
// Counter width, holds 0 up to the larger budget
`define OPX_CRED_W 3

`endif

/* common/opx_pkg.sv */
// Shared types of the operand execute pipeline
// Vector typedefs, ALU operation enum, instruction, forwarding and result packets

`default_nettype none

`include "opx_macros.svh"

package opx_pkg;

	typedef logic [`OPX_DATA_W-1:0] word_t;
	typedef logic [`OPX_REG_AW-1:0] reg_idx_t;
	typedef logic [`OPX_TAG_W-1:0]  tag_t;

	// Shift operations use the low 5 bits of operand B
	typedef enum logic [2:0] {
		ALU_ADD   = 3'd0,
		ALU_SUB   = 3'd1,
		ALU_AND   = 3'd2,
		ALU_OR    = 3'd3,
		ALU_XOR   = 3'd4,
		ALU_SLL   = 3'd5,
		ALU_SRL   = 3'd6,
		// Operand B straight through
		ALU_PASSB = 3'd7
	} alu_op_t;

	// Instruction packet on the input channel
	typedef struct packed {
		tag_t     tag;
		alu_op_t  op;
		reg_idx_t rd;
		reg_idx_t ra;
		reg_idx_t rb;
		logic     use_imm;
		word_t    imm;
	} instr_t;

	// One producer's view for forwarding
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    data;
	} fwd_t;

	// Result packet on the output channel
	typedef struct packed {
		tag_t     tag;
		reg_idx_t rd;
		word_t    data;
	} result_t;

endpackage

`default_nettype wire

/* rtl/opx_issue.sv */
// Input side of the pipeline
// Credit-counted circular instruction queue
// Presents the head entry as the decode slot

`timescale 1ns/1ps
`default_nettype none

`include "opx_macros.svh"

module opx_issue (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire logic            in_valid,
	input  wire opx_pkg::instr_t in_instr,
	input  wire logic            ex_freeze,
	output logic                 in_credit,
	output opx_pkg::instr_t      id_instr,
	output logic                 id_freeze
);

	localparam int PTR_W = $clog2(`OPX_IN_DEPTH);

	opx_pkg::instr_t          queue_mem [`OPX_IN_DEPTH];
	logic [PTR_W-1:0]         wr_ptr;
	logic [PTR_W-1:0]         rd_ptr;
	logic [`OPX_CRED_W-1:0]   count;
	logic                     push;
	logic                     pop;

	// Sender holds credit, so a full queue only sees a protocol error
	assign push = in_valid && (count != `OPX_CRED_W'(`OPX_IN_DEPTH));
	// Decode advances whenever an entry is present and execute is free
	assign pop  = (count != '0) && !ex_freeze;

	// Empty queue means a bubble into execute
	assign id_freeze = (count == '0);
	assign id_instr  = queue_mem[rd_ptr];

	////////////////////////////////////////
	// Pointers, occupancy and credit return
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			in_credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop leaves the count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			// One credit back per entry leaving
			in_credit <= pop;
		end
	end

	// Entry storage
	always_ff @(posedge clk) begin
		if (push)
			queue_mem[wr_ptr] <= in_instr;
	end

endmodule

`default_nettype wire

/* operand/opx_regfile.sv */
// Integer register file
// Sixteen words, two asynchronous read ports, one write port
// Register r0 reads as zero and drops writes

`timescale 1ns/1ps
`default_nettype none

`include "opx_macros.svh"

module opx_regfile (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire opx_pkg::reg_idx_t ra,
	input  wire opx_pkg::reg_idx_t rb,
	input  wire logic              we,
	input  wire opx_pkg::reg_idx_t wa,
	input  wire opx_pkg::word_t    wd,
	output opx_pkg::word_t         rda,
	output opx_pkg::word_t         rdb
);

	localparam int NUM_REGS = 1 << `OPX_REG_AW;

	opx_pkg::word_t regs [NUM_REGS];

	// Write port, r0 stays zero
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we && (wa != '0)) begin
			regs[wa] <= wd;
		end
	end

	// Same-cycle write is not visible here
	// Writeback forwarding supplies that value instead
	assign rda = (ra == '0) ? '0 : regs[ra];
	assign rdb = (rb == '0) ? '0 : regs[rb];

endmodule

`default_nettype wire

/* operand/opx_operand_mux.sv */
// Operand stage of the pipeline
// Forwarding select for operands A and B, immediate for B
// Freeze-aware operand registers with capture-once on bubbles
// Execute control register with its valid bit

`timescale 1ns/1ps
`default_nettype none

module opx_operand_mux (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              id_freeze,
	input  wire logic              ex_freeze,
	input  wire opx_pkg::instr_t   id_instr,
	input  wire opx_pkg::word_t    rf_a,
	input  wire opx_pkg::word_t    rf_b,
	input  wire opx_pkg::fwd_t     ex_fwd,
	input  wire opx_pkg::fwd_t     wb_fwd,
	output opx_pkg::word_t         operand_a,
	output opx_pkg::word_t         operand_b,
	output opx_pkg::instr_t        ex_instr,
	output logic                   ex_valid
);

	// Index 0 is operand A, index 1 is operand B
	opx_pkg::word_t muxed [2];
	opx_pkg::word_t operand_q [2];
	logic [1:0]     saved;

	// Newest producer wins, r0 is never forwarded
	function automatic opx_pkg::word_t pick_src(
		input opx_pkg::reg_idx_t idx,
		input opx_pkg::word_t    rf_data,
		input opx_pkg::fwd_t     ex_v,
		input opx_pkg::fwd_t     wb_v
	);
		if (ex_v.valid && (ex_v.rd == idx) && (idx != '0))
			return ex_v.data;
		else if (wb_v.valid && (wb_v.rd == idx) && (idx != '0))
			return wb_v.data;
		else
			return rf_data;
	endfunction

	////////////////////////////////////////
	// Forwarding select
	////////////////////////////////////////

	always_comb begin
		muxed[0] = pick_src(id_instr.ra, rf_a, ex_fwd, wb_fwd);
		// Immediate takes priority over any forwarding for B
		if (id_instr.use_imm)
			muxed[1] = id_instr.imm;
		else
			muxed[1] = pick_src(id_instr.rb, rf_b, ex_fwd, wb_fwd);
	end

	////////////////////////////////////////
	// Operand registers
	////////////////////////////////////////

	// First bubble cycle captures once and sets saved
	// Later bubbles keep that value, a real instruction always loads
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			saved <= '0;
		end else if (!ex_freeze) begin
			for (int i = 0; i < 2; i++)
				if (!id_freeze || !saved[i])
					saved[i] <= id_freeze;
		end
	end

	always_ff @(posedge clk) begin
		if (!ex_freeze) begin
			for (int i = 0; i < 2; i++)
				if (!id_freeze || !saved[i])
					operand_q[i] <= muxed[i];
		end
	end

	assign operand_a = operand_q[0];
	assign operand_b = operand_q[1];

	// Execute control travels with its operands
	always_ff @(posedge clk) begin
		if (!ex_freeze && !id_freeze)
			ex_instr <= id_instr;
	end

	// Empty decode slot becomes a bubble in execute
	always_ff @(posedge clk) begin
		if (!rst_n)
			ex_valid <= 1'b0;
		else if (!ex_freeze)
			ex_valid <= !id_freeze;
	end

endmodule

`default_nettype wire

/* rtl/opx_alu.sv */
// Execute stage of the pipeline
// Eight-operation combinational ALU
// Builds the execute forwarding view from result, rd and valid

`timescale 1ns/1ps
`default_nettype none

module opx_alu (
	input  wire opx_pkg::word_t  operand_a,
	input  wire opx_pkg::word_t  operand_b,
	input  wire opx_pkg::instr_t ex_instr,
	input  wire logic            ex_valid,
	output opx_pkg::fwd_t        ex_fwd
);

	opx_pkg::word_t result;
	logic [4:0]     shamt;

	// Shift amount from the low bits of B
	assign shamt = operand_b[4:0];

	always_comb begin
		result = '0;
		case (ex_instr.op)
			opx_pkg::ALU_ADD:   result = operand_a + operand_b;
			opx_pkg::ALU_SUB:   result = operand_a - operand_b;
			opx_pkg::ALU_AND:   result = operand_a & operand_b;
			opx_pkg::ALU_OR:    result = operand_a | operand_b;
			opx_pkg::ALU_XOR:   result = operand_a ^ operand_b;
			// Logical shifts, zero fill
			opx_pkg::ALU_SLL:   result = operand_a << shamt;
			opx_pkg::ALU_SRL:   result = operand_a >> shamt;
			opx_pkg::ALU_PASSB: result = operand_b;
			default:            result = '0;
		endcase
	end

	// Bubble in execute never matches a forwarding request
	always_comb begin
		ex_fwd.valid = ex_valid;
		ex_fwd.rd    = ex_instr.rd;
		ex_fwd.data  = result;
	end

endmodule

`default_nettype wire

/* rtl/opx_retire.sv */
// Output side of the pipeline
// Writeback register and output credit counter
// Register file write and pipeline-wide freeze on missing credit

`timescale 1ns/1ps
`default_nettype none

`include "opx_macros.svh"

module opx_retire (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire opx_pkg::fwd_t     ex_fwd,
	input  wire opx_pkg::tag_t     ex_tag,
	input  wire logic              out_credit,
	output opx_pkg::fwd_t          wb_fwd,
	output logic                   out_valid,
	output opx_pkg::result_t       out_result,
	output logic                   ex_freeze,
	output logic                   rf_we,
	output opx_pkg::reg_idx_t      rf_wa,
	output opx_pkg::word_t         rf_wd
);

	logic                   wb_valid;
	opx_pkg::reg_idx_t      wb_rd;
	opx_pkg::word_t         wb_data;
	opx_pkg::tag_t          wb_tag;
	logic [`OPX_CRED_W-1:0] credits;
	logic                   can_send;

	// A credit returning this cycle is usable right away
	assign can_send  = (credits != '0) || out_credit;
	assign out_valid = wb_valid && can_send;
	// Held result with nowhere to go stops every stage
	assign ex_freeze = wb_valid && !can_send;

	////////////////////////////////////////
	// Writeback register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n)
			wb_valid <= 1'b0;
		else if (!ex_freeze)
			wb_valid <= ex_fwd.valid;
	end

	always_ff @(posedge clk) begin
		if (!ex_freeze) begin
			wb_rd   <= ex_fwd.rd;
			wb_data <= ex_fwd.data;
			wb_tag  <= ex_tag;
		end
	end

	// Down on send, up on return, both together cancel
	always_ff @(posedge clk) begin
		if (!rst_n)
			credits <= `OPX_CRED_W'(`OPX_OUT_CREDITS);
		else if (out_valid && !out_credit)
			credits <= credits - 1'b1;
		else if (out_credit && !out_valid)
			credits <= credits + 1'b1;
	end

	assign wb_fwd.valid = wb_valid;
	assign wb_fwd.rd    = wb_rd;
	assign wb_fwd.data  = wb_data;

	assign out_result.tag  = wb_tag;
	assign out_result.rd   = wb_rd;
	assign out_result.data = wb_data;

	// Architectural update in the same cycle as the send
	assign rf_we = out_valid;
	assign rf_wa = wb_rd;
	assign rf_wd = wb_data;

endmodule

`default_nettype wire

/* rtl/opx_core.sv */
// Top level of the operand execute pipeline
// Queue, register file, operand stage, ALU and writeback
// Credit channels on both the input and the output side

`timescale 1ns/1ps
`default_nettype none

module opx_core (
	input  wire logic             clk,
	input  wire logic             rst_n,
	input  wire logic             in_valid,
	input  wire opx_pkg::instr_t  in_instr,
	output logic                  in_credit,
	output logic                  out_valid,
	output opx_pkg::result_t      out_result,
	input  wire logic             out_credit
);

	// Decode slot
	opx_pkg::instr_t   id_instr;
	logic              id_freeze;
	logic              ex_freeze;

	// Register file ports
	opx_pkg::word_t    rf_a;
	opx_pkg::word_t    rf_b;
	logic              rf_we;
	opx_pkg::reg_idx_t rf_wa;
	opx_pkg::word_t    rf_wd;

	// Execute stage
	opx_pkg::word_t    operand_a;
	opx_pkg::word_t    operand_b;
	opx_pkg::instr_t   ex_instr;
	logic              ex_valid;

	// Forwarding views
	opx_pkg::fwd_t     ex_fwd;
	opx_pkg::fwd_t     wb_fwd;

	opx_issue u_issue (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_instr  (in_instr),
		.ex_freeze (ex_freeze),
		.in_credit (in_credit),
		.id_instr  (id_instr),
		.id_freeze (id_freeze)
	);

	opx_regfile u_regfile (
		.clk   (clk),
		.rst_n (rst_n),
		.ra    (id_instr.ra),
		.rb    (id_instr.rb),
		.we    (rf_we),
		.wa    (rf_wa),
		.wd    (rf_wd),
		.rda   (rf_a),
		.rdb   (rf_b)
	);

	opx_operand_mux u_operand_mux (
		.clk       (clk),
		.rst_n     (rst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.id_instr  (id_instr),
		.rf_a      (rf_a),
		.rf_b      (rf_b),
		.ex_fwd    (ex_fwd),
		.wb_fwd    (wb_fwd),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ex_instr  (ex_instr),
		.ex_valid  (ex_valid)
	);

	opx_alu u_alu (
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ex_instr  (ex_instr),
		.ex_valid  (ex_valid),
		.ex_fwd    (ex_fwd)
	);

	// Tag rides beside the forwarding view into writeback
	opx_retire u_retire (
		.clk        (clk),
		.rst_n      (rst_n),
		.ex_fwd     (ex_fwd),
		.ex_tag     (ex_instr.tag),
		.out_credit (out_credit),
		.wb_fwd     (wb_fwd),
		.out_valid  (out_valid),
		.out_result (out_result),
		.ex_freeze  (ex_freeze),
		.rf_we      (rf_we),
		.rf_wa      (rf_wa),
		.rf_wd      (rf_wd)
	);

endmodule

`default_nettype wire

/* tb/opx_core_assertions.sv */
// Concurrent checks bound to the pipeline top level
// Input credit return against instructions in flight
// Output sends against the receiver's credit budget
// Operand register hold while the pipeline is frozen
// Running count of assertion failures

`timescale 1ns/1ps
`default_nettype none

`include "opx_macros.svh"

module opx_core_assertions (
	input wire logic           clk,
	input wire logic           rst_n,
	input wire logic           in_valid,
	input wire logic           in_credit,
	input wire logic           out_valid,
	input wire logic           out_credit,
	input wire logic           ex_freeze,
	input wire opx_pkg::word_t operand_a,
	input wire opx_pkg::word_t operand_b
);

	// Instructions accepted and not yet credited back
	logic [3:0] inflight;
	// Results the receiver can still take
	logic [3:0] out_avail;
	// Failed assertions so far
	int         fail_count = 0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			inflight  <= '0;
			out_avail <= 4'(`OPX_OUT_CREDITS);
		end else begin
			inflight  <= inflight + 4'(in_valid) - 4'(in_credit);
			out_avail <= out_avail - 4'(out_valid) + 4'(out_credit);
		end
	end

	a_in_credit: assert property (@(posedge clk) disable iff (!rst_n)
		in_credit |-> ((inflight != '0) && (inflight <= 4'(`OPX_IN_DEPTH))))
		else begin
			fail_count++;
			$error("input credit returned with no instruction in flight");
		end

	a_out_credit: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> ((out_avail != '0) || out_credit))
		else begin
			fail_count++;
			$error("result sent without output credit");
		end

	// Frozen edge must not load the operand registers
	a_freeze_hold: assert property (@(posedge clk) disable iff (!rst_n)
		ex_freeze |=> ($stable(operand_a) && $stable(operand_b)))
		else begin
			fail_count++;
			$error("operand registers changed during freeze");
		end

endmodule

bind opx_core opx_core_assertions u_assertions (
	.clk        (clk),
	.rst_n      (rst_n),
	.in_valid   (in_valid),
	.in_credit  (in_credit),
	.out_valid  (out_valid),
	.out_credit (out_credit),
	.ex_freeze  (ex_freeze),
	.operand_a  (operand_a),
	.operand_b  (operand_b)
);

`default_nettype wire

/* tb/opx_core_tb.sv */
// Testbench for the operand execute pipeline
// Clock, reset, LFSR stimulus and credit-limited sender
// Reference register model, result queue and compare tasks
// Output back-pressure and cycle timeout

`timescale 1ns/1ps
`default_nettype none

`include "opx_macros.svh"

module opx_core_tb;

	logic               clk;
	logic               rst_n;
	logic               in_valid;
	opx_pkg::instr_t    in_instr;
	logic               in_credit;
	logic               out_valid;
	opx_pkg::result_t   out_result;
	logic               out_credit;

	opx_pkg::word_t     model_regs [16];
	opx_pkg::result_t   exp_q [$];
	string              name_q [$];
	string              test_name;
	logic [31:0]        stim_state;
	logic [31:0]        cred_state;
	int                 tb_credits;
	int                 sent_count;
	int                 received;
	int                 returned;
	int                 credit_pulses;
	int                 owed;
	int                 withhold_left;
	int                 cycles;
	int                 errors;
	logic               bp_on;
	opx_pkg::tag_t      next_tag;

	opx_core uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_instr   (in_instr),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_result (out_result),
		.out_credit (out_credit)
	);

	always #2 clk = ~clk;

	////////////////////////////////////////
	// Random stream and reference model
	////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic draw(input int n, inout logic [31:0] st, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			st = lfsr_next(st);
			v  = {v[30:0], st[0]};
		end
	endtask

	function automatic opx_pkg::word_t ref_exec(input opx_pkg::alu_op_t op,
		input opx_pkg::word_t a, input opx_pkg::word_t b);
		case (op)
			opx_pkg::ALU_ADD: return a + b;
			opx_pkg::ALU_SUB: return a - b;
			opx_pkg::ALU_AND: return a & b;
			opx_pkg::ALU_OR:  return a | b;
			opx_pkg::ALU_XOR: return a ^ b;
			opx_pkg::ALU_SLL: return a << b[4:0];
			opx_pkg::ALU_SRL: return a >> b[4:0];
			default:          return b;
		endcase
	endfunction

	function automatic opx_pkg::instr_t mk(input opx_pkg::alu_op_t op, input int rd,
		input int ra, input int rb, input logic use_imm, input opx_pkg::word_t imm);
		opx_pkg::instr_t i;
		i.tag     = '0;
		i.op      = op;
		i.rd      = opx_pkg::reg_idx_t'(rd);
		i.ra      = opx_pkg::reg_idx_t'(ra);
		i.rb      = opx_pkg::reg_idx_t'(rb);
		i.use_imm = use_imm;
		i.imm     = imm;
		return i;
	endfunction

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic check_word(input string name, input opx_pkg::word_t exp,
		input opx_pkg::word_t act);
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED %s data expected %h actual %h", name, exp, act);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic check_tag(input string name, input opx_pkg::tag_t exp,
		input opx_pkg::tag_t act);
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED %s tag expected %h actual %h", name, exp, act);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic check_idx(input string name, input opx_pkg::reg_idx_t exp,
		input opx_pkg::reg_idx_t act);
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED %s rd expected %h actual %h", name, exp, act);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("%s", what);
		$display("Errors found");
		$fatal(1);
	endtask

	////////////////////////////////////////
	// Sender side
	////////////////////////////////////////

	// Waits for credit, drives one packet and records the model's result
	task automatic send(input opx_pkg::instr_t ins);
		opx_pkg::word_t   a;
		opx_pkg::word_t   b;
		opx_pkg::result_t r;
		@(posedge clk);
		#1;
		while (tb_credits == 0) begin
			in_valid = 1'b0;
			@(posedge clk);
			#1;
		end
		ins.tag  = next_tag;
		next_tag = next_tag + 1'b1;
		in_valid = 1'b1;
		in_instr = ins;
		tb_credits--;
		sent_count++;
		a = (ins.ra == '0) ? '0 : model_regs[ins.ra];
		b = ins.use_imm ? ins.imm : ((ins.rb == '0) ? '0 : model_regs[ins.rb]);
		r.tag  = ins.tag;
		r.rd   = ins.rd;
		r.data = ref_exec(ins.op, a, b);
		if (ins.rd != '0)
			model_regs[ins.rd] = r.data;
		exp_q.push_back(r);
		name_q.push_back(test_name);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			in_valid = 1'b0;
		end
	endtask

	task automatic send_random(input int count, input logic gaps);
		opx_pkg::instr_t ins;
		logic [31:0]     v;
		for (int k = 0; k < count; k++) begin
			draw(3, stim_state, v);
			ins.op = opx_pkg::alu_op_t'(v[2:0]);
			draw(4, stim_state, v);
			ins.rd = v[3:0];
			draw(4, stim_state, v);
			ins.ra = v[3:0];
			draw(4, stim_state, v);
			ins.rb = v[3:0];
			draw(1, stim_state, v);
			ins.use_imm = v[0];
			draw(32, stim_state, v);
			ins.imm = v;
			send(ins);
			if (gaps) begin
				draw(3, stim_state, v);
				idle(int'(v[2:0]));
			end
		end
	endtask

	////////////////////////////////////////
	// Receiver, credit return and monitor
	////////////////////////////////////////

	always begin
		@(posedge clk);
		#1;
		if (bp_on && withhold_left == 0) begin
			logic [31:0] v;
			draw(3, cred_state, v);
			if (v[2:0] == 3'd0) begin
				draw(5, cred_state, v);
				withhold_left = 16 + int'(v[4:0]);
			end
		end
		if (withhold_left > 0) begin
			withhold_left--;
			out_credit = 1'b0;
		end else if (owed > 0) begin
			out_credit = 1'b1;
			owed--;
		end else begin
			out_credit = 1'b0;
		end
	end

	always @(posedge clk) begin
		opx_pkg::result_t exp;
		string            nm;
		if (rst_n) begin
			cycles++;
			if (cycles > 40 * sent_count + 200)
				report_failure("Timeout: results did not arrive within the cycle limit");
			if (uut.u_assertions.fail_count != 0)
				report_failure("A bound assertion on the pipeline failed");
			if (in_credit) begin
				credit_pulses++;
				tb_credits++;
			end
			if (out_credit)
				returned++;
			if (out_valid) begin
				received++;
				owed++;
				if (exp_q.size() == 0)
					report_failure("A result arrived with no instruction outstanding");
				exp = exp_q.pop_front();
				nm  = name_q.pop_front();
				check_tag(nm, exp.tag, out_result.tag);
				check_idx(nm, exp.rd, out_result.rd);
				check_word(nm, exp.data, out_result.data);
			end
			if (received - returned > `OPX_OUT_CREDITS)
				report_failure("More results outstanding than output credits");
		end
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_instr = '0;
		out_credit = 1'b0;
		stim_state = 32'd80546;
		cred_state = 32'd80546;
		tb_credits = `OPX_IN_DEPTH;
		{sent_count, received, returned, credit_pulses, owed} = '0;
		withhold_left = 0;
		cycles = 0;
		errors = 0;
		bp_on = 1'b0;
		next_tag = '0;
		for (int i = 0; i < 16; i++)
			model_regs[i] = '0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Seed every register through immediates
		test_name = "init_regs";
		for (int r = 1; r < 16; r++)
			send(mk(opx_pkg::ALU_PASSB, r, 0, 0, 1'b1, 32'h1357_0000 * r + 32'h9f1 * r * r));
		idle(8);

		test_name = "alu_ops";
		for (int k = 0; k < 8; k++)
			send(mk(opx_pkg::alu_op_t'(k), 8 + k, 1 + (k % 3), 4 + (k % 4), 1'b0, '0));
		idle(8);

		// Distance one, then distance two dependencies
		test_name = "forwarding";
		send(mk(opx_pkg::ALU_ADD, 1, 1, 2, 1'b0, '0));
		send(mk(opx_pkg::ALU_XOR, 3, 1, 4, 1'b0, '0));
		send(mk(opx_pkg::ALU_SUB, 5, 6, 7, 1'b0, '0));
		send(mk(opx_pkg::ALU_OR, 8, 3, 9, 1'b0, '0));
		send(mk(opx_pkg::ALU_SLL, 10, 8, 8, 1'b0, '0));
		send(mk(opx_pkg::ALU_SRL, 11, 8, 10, 1'b0, '0));
		idle(8);

		test_name = "imm_and_r0";
		send(mk(opx_pkg::ALU_ADD, 0, 5, 0, 1'b1, 32'h0000_00ff));
		send(mk(opx_pkg::ALU_ADD, 12, 0, 0, 1'b0, '0));
		send(mk(opx_pkg::ALU_OR, 13, 0, 0, 1'b1, 32'hcafe_0001));
		idle(1);
		send(mk(opx_pkg::ALU_XOR, 14, 0, 13, 1'b0, '0));
		idle(8);

		test_name = "input_gaps";
		send_random(40, 1'b1);

		test_name = "backpressure";
		bp_on = 1'b1;
		send_random(40, 1'b0);
		bp_on = 1'b0;

		test_name = "mixed";
		send_random(30, 1'b1);
		idle(1);

		while (exp_q.size() != 0 || owed != 0 || withhold_left != 0) begin
			@(posedge clk);
			#1;
		end
		idle(6);

		if (credit_pulses != sent_count)
			report_failure("Input credit pulses do not match the instructions accepted");

		if (errors == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Errors found");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

/* opx_core.f */
+incdir+common
common/opx_pkg.sv
rtl/opx_issue.sv
operand/opx_regfile.sv
operand/opx_operand_mux.sv
rtl/opx_alu.sv
rtl/opx_retire.sv
rtl/opx_core.sv
tb/opx_core_assertions.sv
tb/opx_core_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module opx_core_tb -f opx_core.f
	./obj_dir/Vopx_core_tb 2>&1 | tee sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
